// File: hdl/outq_pkg.sv
package outq_pkg;

    // Lane count, fixed at build time
    localparam int unsigned NUM_LANES = 3;

    // Sample and result width
    localparam int unsigned DATA_W = 18;

    // Entries per output FIFO, power of two and at least 2
    localparam int unsigned FIFO_DEPTH = 4;

    // FIFO pointer width follows the depth
    localparam int unsigned PTR_W = $clog2(FIFO_DEPTH);

    // Lane number width, enough for NUM_LANES
    localparam int unsigned LANE_W = 2;

    typedef logic [LANE_W-1:0] lane_id_t;

    // Saturation limits for signed results
    localparam logic signed [DATA_W-1:0] DATA_MAX = {1'b0, {(DATA_W-1){1'b1}}};
    localparam logic signed [DATA_W-1:0] DATA_MIN = {1'b1, {(DATA_W-1){1'b0}}};

    // Lane opcodes
    typedef enum logic [1:0] {
        OP_PASS = 2'd0,
        OP_NEG  = 2'd1,
        OP_ABS  = 2'd2,
        OP_DBL  = 2'd3
    } alu_op_e;

endpackage

// File: hdl/fifo_rd_if.sv
interface fifo_rd_if;

    import outq_pkg::*;

    // Head entry payload
    logic [DATA_W-1:0] data;
    // Head entry occupied
    logic              valid;
    // Two or more entries occupied
    logic              request_wait;
    // Retire head, one pulse per entry
    logic              en_read;

    // FIFO side
    modport fifo (
        output data, valid, request_wait,
        input  en_read
    );

    // Arbiter side
    modport arb (
        input  data, valid, request_wait,
        output en_read
    );

endinterface

// File: hdl/output_fifo.sv
module output_fifo (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Write side, valid/ready
    input  logic [outq_pkg::DATA_W-1:0] data_i,
    input  logic                        valid_i,
    output logic                        ready_o,

    // Read side toward the arbiter
    fifo_rd_if.fifo                     rd
);

    import outq_pkg::*;

    // Entry storage, payload only
    logic [DATA_W-1:0]     mem_q [FIFO_DEPTH];
    // One occupied flag per entry
    logic [FIFO_DEPTH-1:0] valid_q;
    logic [PTR_W-1:0]      wr_ptr_q;
    logic [PTR_W-1:0]      rd_ptr_q;

    logic do_write;
    logic do_read;

    // Write only into a free slot
    assign ready_o  = ~valid_q[wr_ptr_q];
    assign do_write = valid_i & ready_o;

    // Retire only an occupied head
    assign do_read  = rd.en_read & valid_q[rd_ptr_q];

    assign rd.data  = mem_q[rd_ptr_q];
    assign rd.valid = valid_q[rd_ptr_q];

    // More than one bit set means at least two entries waiting
    assign rd.request_wait = (valid_q & (valid_q - 1'b1)) != '0;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            // Write and read never touch the same slot in one cycle
            if (do_write) begin
                valid_q[wr_ptr_q] <= 1'b1;
                wr_ptr_q          <= wr_ptr_q + 1'b1;
            end
            if (do_read) begin
                valid_q[rd_ptr_q] <= 1'b0;
                rd_ptr_q          <= rd_ptr_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_write) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

    // Arbiter must not strobe an empty head
    a_no_read_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rd.en_read |-> rd.valid)
        else $error("output_fifo: read strobe on empty head");

    // Producer keeps its offer while this FIFO is full
    a_wr_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        valid_i && !ready_o |=> valid_i && $stable(data_i))
        else $error("output_fifo: write data dropped while stalled");

endmodule

// File: hdl/lane_alu.sv
module lane_alu (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Sample input, valid/ready
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  outq_pkg::alu_op_e           in_op_i,
    input  logic [outq_pkg::DATA_W-1:0] in_data_i,

    // Result toward the lane FIFO
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [outq_pkg::DATA_W-1:0] out_data_o
);

    import outq_pkg::*;

    logic signed [DATA_W-1:0] din;
    logic signed [DATA_W-1:0] neg_sat;
    logic signed [DATA_W-1:0] result;
    logic                     dbl_ovf;
    logic                     load;

    logic                     out_valid_q;
    logic [DATA_W-1:0]        out_data_q;

    assign din = in_data_i;

    // Negation overflows only for the most negative input
    assign neg_sat = (din == DATA_MIN) ? DATA_MAX : -din;

    // Doubling overflows when the top two bits differ
    assign dbl_ovf = din[DATA_W-1] ^ din[DATA_W-2];

    always_comb begin
        unique case (in_op_i)
            OP_PASS: result = din;
            OP_NEG:  result = neg_sat;
            OP_ABS:  result = din[DATA_W-1] ? neg_sat : din;
            OP_DBL: begin
                if (dbl_ovf) begin
                    result = din[DATA_W-1] ? DATA_MIN : DATA_MAX;
                end else begin
                    result = {din[DATA_W-2:0], 1'b0};
                end
            end
            default: result = din;
        endcase
    end

    // Accept when empty or draining this cycle
    assign in_ready_o = ~out_valid_q | out_ready_i;
    assign load       = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q <= 1'b0;
        end else if (load) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            out_data_q <= result;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;

    // Held result while the FIFO is full
    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
        else $error("lane_alu: output changed while stalled");

endmodule

// File: hdl/out_arbiter.sv
module out_arbiter (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // FIFO read sides, one per lane
    fifo_rd_if.arb                      rd [outq_pkg::NUM_LANES],

    // Shared output port, valid/ready
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [outq_pkg::DATA_W-1:0] out_data_o,
    output outq_pkg::lane_id_t          out_lane_o
);

    import outq_pkg::*;

    // Flattened view of the interface array
    logic [NUM_LANES-1:0] head_valid;
    logic [NUM_LANES-1:0] head_wait;
    logic [DATA_W-1:0]    head_data [NUM_LANES];
    logic [NUM_LANES-1:0] read_strobe;

    logic [NUM_LANES-1:0] urgent;
    logic [NUM_LANES-1:0] cand;
    lane_id_t             grant_lane;
    logic                 grant_any;
    logic                 out_free;
    logic                 take;

    lane_id_t             last_q;
    logic                 out_valid_q;
    logic [DATA_W-1:0]    out_data_q;
    lane_id_t             out_lane_q;

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
        assign head_valid[g] = rd[g].valid;
        assign head_wait[g]  = rd[g].request_wait;
        assign head_data[g]  = rd[g].data;
        assign rd[g].en_read = read_strobe[g];
    end

    // Urgent lanes first, otherwise any lane with a head entry
    assign urgent = head_valid & head_wait;
    assign cand   = (urgent != '0) ? urgent : head_valid;

    // Round robin starting one past the last winner
    always_comb begin : pick
        int unsigned idx;
        grant_lane = '0;
        grant_any  = 1'b0;
        for (int unsigned off = 1; off <= NUM_LANES; off++) begin
            idx = (int'(last_q) + off) % NUM_LANES;
            if (!grant_any && cand[idx]) begin
                grant_any  = 1'b1;
                grant_lane = lane_id_t'(idx);
            end
        end
    end

    // Output register free now or at this edge
    assign out_free = ~out_valid_q | out_ready_i;
    assign take     = grant_any & out_free;

    always_comb begin
        read_strobe = '0;
        if (take) begin
            read_strobe[grant_lane] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            out_valid_q <= 1'b0;
            // Lane 0 goes first after reset
            last_q      <= lane_id_t'(NUM_LANES - 1);
        end else if (take) begin
            out_valid_q <= 1'b1;
            last_q      <= grant_lane;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (take) begin
            out_data_q <= head_data[grant_lane];
            out_lane_q <= grant_lane;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_data_o  = out_data_q;
    assign out_lane_o  = out_lane_q;

    // At most one FIFO retired per cycle and urgent lanes served first
    a_read_pick: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(read_strobe) &&
        ((read_strobe & ~head_wait) == '0 || (head_valid & head_wait) == '0))
        else $error("out_arbiter: read strobe not one-hot or not urgent first");

    // Result and lane held while the consumer stalls
    a_out_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
        out_valid_o && !out_ready_i |=>
            out_valid_o && $stable(out_data_o) && $stable(out_lane_o))
        else $error("out_arbiter: output changed while stalled");

endmodule

// File: hdl/outq_top.sv
module outq_top (
    input  logic                                                   clk_i,
    input  logic                                                   rst_ni,

    // Lane inputs, indexed by lane
    input  logic [outq_pkg::NUM_LANES-1:0]                         in_valid_i,
    output logic [outq_pkg::NUM_LANES-1:0]                         in_ready_o,
    input  outq_pkg::alu_op_e [outq_pkg::NUM_LANES-1:0]            in_op_i,
    input  logic [outq_pkg::NUM_LANES-1:0][outq_pkg::DATA_W-1:0]   in_data_i,

    // Collected results with source lane
    output logic                                                   out_valid_o,
    input  logic                                                   out_ready_i,
    output logic [outq_pkg::DATA_W-1:0]                            out_data_o,
    output outq_pkg::lane_id_t                                     out_lane_o
);

    import outq_pkg::*;

    // ALU to FIFO links
    logic [NUM_LANES-1:0] alu_valid;
    logic [NUM_LANES-1:0] alu_ready;
    logic [DATA_W-1:0]    alu_data [NUM_LANES];

    // FIFO read sides shared with the arbiter
    fifo_rd_if rd_if [NUM_LANES] ();

    for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane

        lane_alu u_alu (
            .clk_i       (clk_i),
            .rst_ni      (rst_ni),
            .in_valid_i  (in_valid_i[g]),
            .in_ready_o  (in_ready_o[g]),
            .in_op_i     (in_op_i[g]),
            .in_data_i   (in_data_i[g]),
            .out_valid_o (alu_valid[g]),
            .out_ready_i (alu_ready[g]),
            .out_data_o  (alu_data[g])
        );

        // Back-pressure reaches the ALU through ready_o
        output_fifo u_fifo (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .data_i  (alu_data[g]),
            .valid_i (alu_valid[g]),
            .ready_o (alu_ready[g]),
            .rd      (rd_if[g])
        );

    end

    out_arbiter u_arb (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rd          (rd_if),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_lane_o  (out_lane_o)
    );

endmodule

// File: tb/tb_outq_top.sv
module tb_outq_top;

    import outq_pkg::*;

    localparam int CLK_PERIOD     = 40;
    localparam int ITEMS_PER_LANE = 200;
    localparam int STALL_START    = 50;
    // Budget of 40 cycles per item, plus margin
    localparam int WATCHDOG_TIME  = (ITEMS_PER_LANE * NUM_LANES * 40 + 1000) * CLK_PERIOD;

    logic                               clk_i;
    logic                               rst_ni;
    logic [NUM_LANES-1:0]               in_valid_i;
    logic [NUM_LANES-1:0]               in_ready_o;
    alu_op_e [NUM_LANES-1:0]            in_op_i;
    logic [NUM_LANES-1:0][DATA_W-1:0]   in_data_i;
    logic                               out_valid_o;
    logic                               out_ready_i;
    logic [DATA_W-1:0]                  out_data_o;
    lane_id_t                           out_lane_o;

    integer seed = 32'ha6401fd0;

    // Scoreboard, one queue of expected results per lane
    logic [DATA_W-1:0] exp_q [NUM_LANES][$];
    int in_cnt [NUM_LANES];
    int out_cnt [NUM_LANES];
    int in_total;
    int out_total;
    int err_value;
    int err_other;
    logic drivers_done;

    outq_top dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .in_valid_i  (in_valid_i),
        .in_ready_o  (in_ready_o),
        .in_op_i     (in_op_i),
        .in_data_i   (in_data_i),
        .out_valid_o (out_valid_o),
        .out_ready_i (out_ready_i),
        .out_data_o  (out_data_o),
        .out_lane_o  (out_lane_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    // Saturating result straight from the opcode rules
    function automatic logic [DATA_W-1:0] expected_result(input alu_op_e op,
                                                          input logic [DATA_W-1:0] d);
        int v;
        int r;
        v = int'($signed(d));
        case (op)
            OP_PASS: r = v;
            OP_NEG:  r = -v;
            OP_ABS:  r = (v < 0) ? -v : v;
            default: r = 2 * v;
        endcase
        // Clamp to the 18-bit signed range
        if (r > int'(DATA_MAX)) r = int'(DATA_MAX);
        if (r < int'(DATA_MIN)) r = int'(DATA_MIN);
        return r[DATA_W-1:0];
    endfunction

    // Results still expected over all lanes
    function automatic int pending_results();
        int n;
        n = 0;
        for (int l = 0; l < NUM_LANES; l++) begin
            n += exp_q[l].size();
        end
        return n;
    endfunction

    // Input transfers push, output transfers pop and compare
    always @(posedge clk_i) begin : scoreboard
        logic [DATA_W-1:0] expv;
        if (rst_ni) begin
            for (int l = 0; l < NUM_LANES; l++) begin
                if (in_valid_i[l] && in_ready_o[l]) begin
                    exp_q[l].push_back(expected_result(in_op_i[l], in_data_i[l]));
                    in_cnt[l]++;
                    in_total++;
                end
            end
            if (out_valid_o && out_ready_i) begin
                out_total++;
                if (out_lane_o >= NUM_LANES) begin
                    err_other++;
                    $display("Output names lane %0d, which does not exist", out_lane_o);
                end else if (exp_q[out_lane_o].size() == 0) begin
                    err_other++;
                    $display("Output from lane %0d with no result pending", out_lane_o);
                end else begin
                    expv = exp_q[out_lane_o].pop_front();
                    out_cnt[out_lane_o]++;
                    assert (out_data_o == expv) else begin
                        err_value++;
                        $display("ERR out_data_o lane %0d got %h expected %h",
                                 out_lane_o, out_data_o, expv);
                    end
                end
            end
        end
    end

    // One lane's stream, edge cases mixed with random samples
    task automatic lane_driver(input int lane);
        logic [DATA_W-1:0] d;
        for (int n = 0; n < ITEMS_PER_LANE; n++) begin
            // Occasional idle cycle
            if (($random(seed) & 3) == 0) begin
                @(posedge clk_i);
                #5;
            end
            case ($random(seed) & 7)
                0:       d = DATA_MAX;
                1:       d = DATA_MIN;
                2:       d = '0;
                3:       d = DATA_MIN + 1'b1;
                default: d = DATA_W'($random(seed));
            endcase
            in_valid_i[lane] = 1'b1;
            in_op_i[lane]    = alu_op_e'($random(seed) & 3);
            in_data_i[lane]  = d;
            do @(posedge clk_i); while (!in_ready_o[lane]);
            #5;
            in_valid_i[lane] = 1'b0;
        end
    endtask

    // Hold the output port for 30 cycles and watch it freeze
    task automatic stall_window();
        logic              ref_valid;
        logic [DATA_W-1:0] ref_data;
        logic [NUM_LANES-1:0] low_seen;
        out_ready_i = 1'b0;
        // Register may still load at this first edge
        @(posedge clk_i);
        #5;
        ref_valid = out_valid_o;
        ref_data  = out_data_o;
        low_seen  = ~in_ready_o;
        repeat (29) begin
            @(posedge clk_i);
            #5;
            assert (out_valid_o == ref_valid) else begin
                err_value++;
                $display("ERR out_valid_o held %h now %h", ref_valid, out_valid_o);
            end
            assert (out_data_o == ref_data) else begin
                err_value++;
                $display("ERR out_data_o held %h now %h", ref_data, out_data_o);
            end
            low_seen |= ~in_ready_o;
        end
        assert (ref_valid) else begin
            err_other++;
            $display("No result waiting on the output during the stall");
        end
        assert (&low_seen) else begin
            err_other++;
            $display("Back-pressure did not reach every lane input during the stall");
        end
        out_ready_i = 1'b1;
    endtask

    // Random stalls until every sent item has come out
    task automatic ready_driver();
        int cycle;
        cycle = 0;
        while (!drivers_done || pending_results() != 0) begin
            if (cycle == STALL_START) begin
                stall_window();
            end else begin
                out_ready_i = ($random(seed) & 3) != 0;
            end
            @(posedge clk_i);
            #5;
            cycle++;
        end
        out_ready_i = 1'b1;
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout, the run did not drain within the time budget");
        $display("tests failed");
        $finish;
    end

    initial begin
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        in_valid_i   = '0;
        in_data_i    = '0;
        out_ready_i  = 1'b0;
        drivers_done = 1'b0;
        for (int l = 0; l < NUM_LANES; l++) begin
            in_op_i[l] = OP_PASS;
        end
        repeat (16) @(posedge clk_i);
        #5;
        rst_ni = 1'b1;
        // Idle state straight after reset
        assert (!out_valid_o && &in_ready_o) else begin
            err_other++;
            $display("After reset the output is valid or a lane input is not ready");
        end
        fork
            begin
                fork
                    lane_driver(0);
                    lane_driver(1);
                    lane_driver(2);
                join
                drivers_done = 1'b1;
            end
            ready_driver();
        join
        repeat (2) @(posedge clk_i);
        for (int l = 0; l < NUM_LANES; l++) begin
            assert (exp_q[l].size() == 0 && out_cnt[l] == ITEMS_PER_LANE) else begin
                err_other++;
                $display("Lane %0d sent %0d items but %0d came out", l, in_cnt[l], out_cnt[l]);
            end
        end
        assert (out_total == in_total) else begin
            err_other++;
            $display("Total output count differs from total input count");
        end
        $display("results %0d, value errors %0d, other errors %0d",
                 out_total, err_value, err_other);
        if (err_value + err_other == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
hdl/outq_pkg.sv
hdl/fifo_rd_if.sv
hdl/output_fifo.sv
hdl/lane_alu.sv
hdl/out_arbiter.sv
hdl/outq_top.sv
tb/tb_outq_top.sv
